// File: verilog/pbusPkg.sv
`default_nettype none

package pbusPkg;

	// Slot counter
	localparam int slotWidth = 4;                  // Bits in the slot counter
	localparam int slotCount = 1 << slotWidth;     // 16 mclk per P cycle

	// Bus and ROM address widths
	localparam int pbusWidth     = 24;             // Full P bus
	localparam int sRomAddrWidth = 16;             // Fix ROM address
	localparam int cRomAddrWidth = 24;             // Sprite ROM address

	// FT, fix ROM address
	localparam logic [slotWidth-1:0] slotFixAddrFirst = 4'd0;
	localparam logic [slotWidth-1:0] slotFixAddrLast  = 4'd1;   // Fix latch strobe slot

	// X, sprite X position
	localparam logic [slotWidth-1:0] slotXPosFirst = 4'd2;
	localparam logic [slotWidth-1:0] slotXPosLast  = 4'd6;

	// FP, fix palette
	localparam logic [slotWidth-1:0] slotFixPal = 4'd7;

	// ST, sprite ROM address
	localparam logic [slotWidth-1:0] slotSprAddrFirst = 4'd8;
	localparam logic [slotWidth-1:0] slotSprAddrLast  = 4'd9;   // Sprite latch strobe slot

	// LO, line-zero ROM address, also the nVCS window
	localparam logic [slotWidth-1:0] slotL0First = 4'd10;
	localparam logic [slotWidth-1:0] slotL0Last  = 4'd14;

	// SP, sprite palette
	localparam logic [slotWidth-1:0] slotSprPal = 4'd15;

	// L0 data taken at the edge closing this slot
	localparam logic [slotWidth-1:0] slotL0Capture = 4'd14;

	// Latch payloads
	typedef logic [sRomAddrWidth-1:0] fixAddr_t;   // Board fix address latch
	typedef logic [cRomAddrWidth-1:0] sprAddr_t;   // Board sprite address latch

endpackage

`default_nettype wire

// File: verilog/pbusLatch.sv
`timescale 1ns/10ps
`default_nettype none

module pbusLatch
#(
	parameter type payload_t = pbusPkg::fixAddr_t      // Latch width follows payload
)
(
	input  logic                           CLK_24M,
	input  logic                           nRESET,
	input  logic                           strobe,     // One slot wide
	input  logic [pbusPkg::pbusWidth-1:0]  PBUS,
	output payload_t                       q
);

	localparam int payloadWidth = $bits(payload_t);    // Low bus bits used

	// Capture at the edge closing the strobe slot
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			q <= '0;
		else if (strobe)
			q <= payload_t'(PBUS[payloadWidth-1:0]);
	end

endmodule

`default_nettype wire

// File: verilog/fixAddrGen.sv
`timescale 1ns/10ps
`default_nettype none

module fixAddrGen
(
	input  logic               CLK_24M,
	input  logic               nRESET,
	input  logic               cycleEnd,      // Slot 15 of the P cycle

	input  logic [10:0]        fixTile,       // Tile number from fix map
	input  logic [2:0]         fixLine,       // Line within tile
	input  logic [3:0]         fixPalIn,      // Palette from fix map

	output pbusPkg::fixAddr_t  sRomAddr,
	output logic [3:0]         fixPal,
	output logic               S2H1
);

	logic [1:0]  pairIdx;     // Pixel pair within the tile row
	logic [10:0] tileReg;     // Sampled tile
	logic [3:0]  palReg;      // Sampled palette
	logic        sampled;     // Set once a tile has been taken

	logic        takeTile;    // Sample at this cycle end

	// New tile on the 3 to 0 wrap, or the first cycle out of reset
	assign takeTile = cycleEnd && ((pairIdx == 2'd3) || !sampled);

	// Pair index, one step per P cycle
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			pairIdx <= '0;
			sampled <= 1'b0;
		end
		else if (cycleEnd)
		begin
			pairIdx <= pairIdx + 1'b1;
			sampled <= 1'b1;
		end
	end

	// Tile and palette hold for four cycles
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			tileReg <= '0;
			palReg  <= '0;
		end
		else if (takeTile)
		begin
			tileReg <= fixTile;
			palReg  <= fixPalIn;
		end
	end

	// Tile, pair, line from MSB down
	assign sRomAddr = {tileReg, pairIdx, fixLine};
	assign fixPal   = palReg;
	assign S2H1     = pairIdx[0];       // Half select for the pixel pair

endmodule

`default_nettype wire

// File: verilog/pCycle.sv
`timescale 1ns/10ps
`default_nettype none

module pCycle
(
	input  logic                                CLK_24M,
	input  logic                                nRESET,

	input  pbusPkg::fixAddr_t                   sRomAddr,       // From fix generator
	input  logic [3:0]                          fixPal,
	input  pbusPkg::sprAddr_t                   cRomAddr,
	input  logic [7:0]                          sprPal,
	input  logic [7:0]                          sprXPos,
	input  logic [15:0]                         l0RomAddr,
	input  logic [7:0]                          l0RomData,

	output logic [pbusPkg::pbusWidth-1:0]       PBUS,
	output logic                                pbusUpperEn,    // Low = upper byte released
	output logic                                S1H1,
	output logic                                nVCS,
	output logic [7:0]                          l0Data,

	output logic                                fixLatchStrobe,
	output logic                                sprLatchStrobe,
	output logic                                cycleEnd
);

	logic [pbusPkg::slotWidth-1:0] slot;    // Current time slot

	logic inFixAddr;                        // FT
	logic inXPos;                           // X
	logic inFixPal;                         // FP
	logic inSprAddr;                        // ST
	logic inL0;                             // LO
	logic inSprPal;                         // SP

	// Free-running slot counter
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			slot <= '0;
		else
			slot <= slot + 1'b1;                // Wraps every 16
	end

	// Slot range decode
	always_comb
	begin
		inFixAddr = (slot >= pbusPkg::slotFixAddrFirst) && (slot <= pbusPkg::slotFixAddrLast);
		inXPos    = (slot >= pbusPkg::slotXPosFirst) && (slot <= pbusPkg::slotXPosLast);
		inFixPal  = (slot == pbusPkg::slotFixPal);
		inSprAddr = (slot >= pbusPkg::slotSprAddrFirst) && (slot <= pbusPkg::slotSprAddrLast);
		inL0      = (slot >= pbusPkg::slotL0First) && (slot <= pbusPkg::slotL0Last);
		inSprPal  = (slot == pbusPkg::slotSprPal);
	end

	// P bus mux, upper byte zero when released
	always_comb
	begin
		PBUS = '0;                               // Covers no decoded slot
		if (inFixAddr)
			PBUS = {8'h00, sRomAddr};
		else if (inXPos)
			PBUS = {8'h00, sprXPos, 8'h00};
		else if (inFixPal)
			PBUS = {4'h0, fixPal, 16'h0000};     // Palette on bits 19:16
		else if (inSprAddr)
			PBUS = cRomAddr;
		else if (inL0)
			PBUS = {8'h00, l0RomAddr};
		else if (inSprPal)
			PBUS = {sprPal, 16'h0000};
	end

	// Upper byte only driven in FP, ST and SP
	assign pbusUpperEn = ~(inFixAddr | inXPos | inL0);

	// Pixel pair latch, second half of the cycle
	assign S1H1 = slot[pbusPkg::slotWidth-1];

	// L0 ROM select spans the LO slots
	assign nVCS = ~inL0;

	// Board latch strobes, one slot each
	assign fixLatchStrobe = (slot == pbusPkg::slotFixAddrLast);
	assign sprLatchStrobe = (slot == pbusPkg::slotSprAddrLast);

	// Last slot of the cycle, steps the fix generator
	assign cycleEnd = (slot == pbusPkg::slotWidth'(pbusPkg::slotCount - 1));

	// Line-zero data, taken as nVCS closes
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			l0Data <= '0;
		else if (slot == pbusPkg::slotL0Capture)
			l0Data <= l0RomData;                 // Held until next capture
	end

endmodule

`default_nettype wire

// File: verilog/videoPbus.sv
`timescale 1ns/10ps
`default_nettype none

module videoPbus
(
	input  logic                           CLK_24M,
	input  logic                           nRESET,

	input  logic [10:0]                    fixTile,
	input  logic [2:0]                     fixLine,
	input  logic [3:0]                     fixPalIn,

	input  pbusPkg::sprAddr_t              cRomAddr,
	input  logic [7:0]                     sprPal,
	input  logic [7:0]                     sprXPos,

	input  logic [15:0]                    l0RomAddr,
	input  logic [7:0]                     l0RomData,

	output logic [pbusPkg::pbusWidth-1:0]  PBUS,
	output logic                           pbusUpperEn,
	output logic                           S1H1,
	output logic                           S2H1,
	output logic                           nVCS,
	output logic [7:0]                     l0Data,

	output pbusPkg::fixAddr_t              fixRomAddr,   // Board fix latch
	output pbusPkg::sprAddr_t              sprRomAddr    // Board sprite latch
);

	pbusPkg::fixAddr_t sRomAddr;      // Generated fix address
	logic [3:0]        fixPal;        // Sampled fix palette
	logic              fixLatchStrobe;
	logic              sprLatchStrobe;
	logic              cycleEnd;

	fixAddrGen fixAddrGen (
		.CLK_24M   (CLK_24M),
		.nRESET    (nRESET),
		.cycleEnd  (cycleEnd),
		.fixTile   (fixTile),
		.fixLine   (fixLine),
		.fixPalIn  (fixPalIn),
		.sRomAddr  (sRomAddr),
		.fixPal    (fixPal),
		.S2H1      (S2H1)
	);

	pCycle pCycle (
		.CLK_24M        (CLK_24M),
		.nRESET         (nRESET),
		.sRomAddr       (sRomAddr),
		.fixPal         (fixPal),
		.cRomAddr       (cRomAddr),
		.sprPal         (sprPal),
		.sprXPos        (sprXPos),
		.l0RomAddr      (l0RomAddr),
		.l0RomData      (l0RomData),
		.PBUS           (PBUS),
		.pbusUpperEn    (pbusUpperEn),
		.S1H1           (S1H1),
		.nVCS           (nVCS),
		.l0Data         (l0Data),
		.fixLatchStrobe (fixLatchStrobe),
		.sprLatchStrobe (sprLatchStrobe),
		.cycleEnd       (cycleEnd)
	);

	// Fix ROM address, low 16 bits in slot 1
	pbusLatch #(.payload_t(pbusPkg::fixAddr_t)) fixLatch (
		.CLK_24M (CLK_24M),
		.nRESET  (nRESET),
		.strobe  (fixLatchStrobe),
		.PBUS    (PBUS),
		.q       (fixRomAddr)
	);

	// Sprite ROM address, full bus in slot 9
	pbusLatch #(.payload_t(pbusPkg::sprAddr_t)) sprLatch (
		.CLK_24M (CLK_24M),
		.nRESET  (nRESET),
		.strobe  (sprLatchStrobe),
		.PBUS    (PBUS),
		.q       (sprRomAddr)
	);

endmodule

`default_nettype wire

// File: test/videoPbus_assert.sv
`timescale 1ns/10ps
`default_nettype none

module videoPbus_assert
(
	input  logic        CLK_24M,
	input  logic        nRESET,
	input  logic        nVCS,
	input  logic        fixLatchStrobe,
	input  logic        sprLatchStrobe,
	input  logic        cycleEnd,
	input  logic        pbusUpperEn,
	input  logic [3:0]  slot            // Internal slot counter of pCycle
);

	// L0 chip select, five clocks low then released
	nvcsWindow: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$fell(nVCS) |-> ##1 !nVCS ##1 !nVCS ##1 !nVCS ##1 !nVCS ##1 nVCS)
		else $error("nVCS window is not five clocks");

	// Strobes are single clock pulses
	fixStrobeWidth: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		fixLatchStrobe |=> !fixLatchStrobe)
		else $error("fix latch strobe wider than one clock");
	sprStrobeWidth: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		sprLatchStrobe |=> !sprLatchStrobe)
		else $error("sprite latch strobe wider than one clock");

	// One strobe per 16 clock cycle
	fixStrobePeriod: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		fixLatchStrobe |-> ##16 fixLatchStrobe)
		else $error("fix latch strobe period is not 16 clocks");
	sprStrobePeriod: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		sprLatchStrobe |-> ##16 sprLatchStrobe)
		else $error("sprite latch strobe period is not 16 clocks");

	// Wrap into FT with upper byte released
	cycleWrap: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		cycleEnd |=> (slot == 4'd0) && !pbusUpperEn)
		else $error("cycle end not followed by a released slot 0");

endmodule

bind pCycle videoPbus_assert pCycleChecks (
	.CLK_24M        (CLK_24M),
	.nRESET         (nRESET),
	.nVCS           (nVCS),
	.fixLatchStrobe (fixLatchStrobe),
	.sprLatchStrobe (sprLatchStrobe),
	.cycleEnd       (cycleEnd),
	.pbusUpperEn    (pbusUpperEn),
	.slot           (slot)
);

`default_nettype wire

// File: test/videoPbusTb.sv
`timescale 1ns/10ps
`default_nettype none

module videoPbusTb;

	localparam int resetClocks    = 10;
	localparam int cycleClocks    = 16;        // One P cycle
	localparam int strobeCycles   = 4;
	localparam int slotCycles     = 8;
	localparam int l0Cycles       = 6;
	localparam int latchCycles    = 6;
	localparam int fixCycles      = 24;        // Six tiles of four pairs
	localparam int testClocks     = cycleClocks *
		(strobeCycles + slotCycles + l0Cycles + latchCycles + fixCycles) + 8;
	localparam int watchdogClocks = resetClocks + testClocks + 100;

	// Stimulus kinds per phase
	localparam int modeIdle   = 0;
	localparam int modeSprite = 1;
	localparam int modeL0     = 2;
	localparam int modeLatch  = 3;
	localparam int modeFix    = 4;

	logic        CLK_24M;
	logic        nRESET;
	logic [10:0] fixTile;
	logic [2:0]  fixLine;
	logic [3:0]  fixPalIn;
	logic [23:0] cRomAddr;
	logic [7:0]  sprPal;
	logic [7:0]  sprXPos;
	logic [15:0] l0RomAddr;
	logic [7:0]  l0RomData;

	logic [23:0] PBUS;
	logic        pbusUpperEn;
	logic        S1H1;
	logic        S2H1;
	logic        nVCS;
	logic [7:0]  l0Data;
	logic [15:0] fixRomAddr;
	logic [23:0] sprRomAddr;

	logic [3:0]  tbSlot;                   // Clocks since release mod 16
	logic [1:0]  pairModel;
	logic [10:0] tileModel;
	logic [3:0]  palModel;
	logic        sampledModel;             // First tile taken
	logic [7:0]  expL0;
	logic [15:0] expFixLatch;
	logic [23:0] expSprLatch;
	logic [26:0] expVec;                   // {S1H1, nVCS, upperEn, PBUS}

	int errorCount;
	int checkCount;
	int testCount;
	int testFails;

	videoPbus dut (.*);

	initial
	begin
		CLK_24M = 1'b0;
		forever #10 CLK_24M = ~CLK_24M;   // 20 ns period
	end

	// Expected bus word from the slot table
	function automatic logic [26:0] expectBus(input logic [3:0] s, input logic [15:0] fixAddr,
		input logic [3:0] pal, input logic [23:0] cAddr, input logic [7:0] sPal,
		input logic [7:0] xPos, input logic [15:0] l0Addr);
		logic [23:0] bus;
		logic        inLo;
		logic        upEn;
		logic        vcs;
		case (s)
			4'd0, 4'd1:                        bus = {8'h00, fixAddr};
			4'd2, 4'd3, 4'd4, 4'd5, 4'd6:      bus = {8'h00, xPos, 8'h00};
			4'd7:                              bus = {4'h0, pal, 16'h0000};
			4'd8, 4'd9:                        bus = cAddr;
			4'd10, 4'd11, 4'd12, 4'd13, 4'd14: bus = {8'h00, l0Addr};
			default:                           bus = {sPal, 16'h0000};
		endcase
		inLo = (s >= 4'd10) && (s <= 4'd14);
		upEn = !((s <= 4'd6) || inLo);      // Released in FT, X and LO
		vcs  = !inLo;                       // Low only in LO
		return {s[3], vcs, upEn, bus};
	endfunction

	task automatic failValue(input string what, input logic [23:0] got, input logic [23:0] exp);
		$display("FAIL %0d ns: %s wrong in slot %0d, got %h expected %h",
			$time, what, tbSlot, got, exp);
		errorCount = errorCount + 1;
	endtask

	task automatic reportTest(input string name, input int errs);
		testCount = testCount + 1;
		if (errs != 0)
			testFails = testFails + 1;
		$display("Test %0d %-16s finished with %0d errors", testCount, name, errs);
	endtask

	// One clock then model update from the values the DUT just sampled
	task automatic stepClock;
		@(posedge CLK_24M);
		#1;
		if (tbSlot == 4'd1)
			expFixLatch = {tileModel, pairModel, fixLine};
		if (tbSlot == 4'd9)
			expSprLatch = cRomAddr;
		if (tbSlot == 4'd14)
			expL0 = l0RomData;              // Captured as nVCS closes
		if (tbSlot == 4'd15)
		begin
			if ((pairModel == 2'd3) || !sampledModel)
			begin
				tileModel = fixTile;
				palModel  = fixPalIn;
			end
			pairModel    = pairModel + 2'd1;
			sampledModel = 1'b1;
		end
		tbSlot = tbSlot + 4'd1;
	endtask

	task automatic runPhase(input string name, input int cycles, input int mode);
		int startErrors;
		int i;
		startErrors = errorCount;
		for (i = 0; i < cycles * cycleClocks; i++)
		begin
			stepClock();
			case (mode)
				modeSprite:
				begin
					cRomAddr  = 24'($urandom);
					sprPal    = 8'($urandom);
					sprXPos   = 8'($urandom);
					l0RomAddr = 16'($urandom);
				end
				modeL0:    l0RomData = 8'($urandom);
				modeLatch:
				begin
					cRomAddr = 24'($urandom);
					fixLine  = 3'($urandom);
				end
				modeFix:
				begin
					if ($urandom % 6 == 0)   // Tile map changes at odd times
					begin
						fixTile  = 11'($urandom);
						fixPalIn = 4'($urandom);
					end
				end
				default: ;
			endcase
		end
		@(negedge CLK_24M);                 // Let the last check land
		#1;
		reportTest(name, errorCount - startErrors);
	endtask

	// Comparator at mid-clock where everything has settled
	always @(negedge CLK_24M)
	begin
		checkCount = checkCount + 1;
		if (!nRESET)
		begin
			if (nVCS !== 1'b1)
				failValue("nVCS in reset", 24'(nVCS), 24'h1);
			if (l0Data !== 8'h00)
				failValue("l0Data in reset", 24'(l0Data), 24'h0);
			if (fixRomAddr !== 16'h0000)
				failValue("fixRomAddr in reset", 24'(fixRomAddr), 24'h0);
			if (sprRomAddr !== 24'h000000)
				failValue("sprRomAddr in reset", sprRomAddr, 24'h0);
		end
		else
		begin
			expVec = expectBus(tbSlot, {tileModel, pairModel, fixLine}, palModel,
				cRomAddr, sprPal, sprXPos, l0RomAddr);
			if (PBUS !== expVec[23:0])
				failValue("PBUS", PBUS, expVec[23:0]);
			if (pbusUpperEn !== expVec[24])
				failValue("pbusUpperEn", 24'(pbusUpperEn), 24'(expVec[24]));
			if (nVCS !== expVec[25])
				failValue("nVCS", 24'(nVCS), 24'(expVec[25]));
			if (S1H1 !== expVec[26])
				failValue("S1H1", 24'(S1H1), 24'(expVec[26]));
			if (S2H1 !== pairModel[0])
				failValue("S2H1", 24'(S2H1), 24'(pairModel[0]));
			if (l0Data !== expL0)
				failValue("l0Data", 24'(l0Data), 24'(expL0));
			if (fixRomAddr !== expFixLatch)
				failValue("fixRomAddr", 24'(fixRomAddr), 24'(expFixLatch));
			if (sprRomAddr !== expSprLatch)
				failValue("sprRomAddr", sprRomAddr, expSprLatch);
		end
	end

	initial
	begin
		l0RomData    = 8'($urandom(32'h8139));  // Seeds the generator once
		nRESET       = 1'b0;
		fixTile      = 11'h2a5;
		fixLine      = 3'd3;
		fixPalIn     = 4'h9;
		cRomAddr     = 24'h123456;
		sprPal       = 8'h5c;
		sprXPos      = 8'h81;
		l0RomAddr    = 16'hbeef;
		tbSlot       = 4'd0;
		pairModel    = 2'd0;
		tileModel    = 11'd0;
		palModel     = 4'd0;
		sampledModel = 1'b0;
		expL0        = 8'h00;
		expFixLatch  = 16'h0000;
		expSprLatch  = 24'h000000;
		errorCount   = 0;
		checkCount   = 0;
		testCount    = 0;
		testFails    = 0;

		repeat (resetClocks) @(posedge CLK_24M);
		#1;
		nRESET = 1'b1;                      // Slot 0 until the next edge
		@(negedge CLK_24M);
		#1;
		reportTest("reset state", errorCount);

		runPhase("strobes", strobeCycles, modeIdle);
		runPhase("slot contents", slotCycles, modeSprite);
		runPhase("line-zero capture", l0Cycles, modeL0);
		runPhase("address latches", latchCycles, modeLatch);
		runPhase("fix sequencing", fixCycles, modeFix);

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, testFails, checkCount, errorCount);
		if ((errorCount == 0) && (testFails == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Watchdog sized from the test lengths
	initial
	begin
		#(watchdogClocks * 20);
		$display("Timeout: tests did not finish within %0d clocks", watchdogClocks);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: videoPbus.f
verilog/pbusPkg.sv
verilog/pbusLatch.sv
verilog/fixAddrGen.sv
verilog/pCycle.sv
verilog/videoPbus.sv
test/videoPbus_assert.sv
test/videoPbusTb.sv

// File: Makefile
# Verilator flow for the P bus slot generator

VERILATOR ?= verilator
TOP       ?= videoPbusTb
FILELIST  ?= videoPbus.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Result: PASSED

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
